// File: systolic_pkg.sv
package systolic_pkg;

    // grid and operand sizes
    localparam int ARRAY_SIZE = 4;
    localparam int OPERAND_W  = 8;
    localparam int PRODUCT_W  = 16;

    // radix-8 digits needed to cover an 8-bit signed operand
    localparam int NUM_DIGITS = 3;

    // operand/3y register, carry-save register, product register
    localparam int MULT_LATENCY = 3;

    // skew through the grid plus multiplier, accumulator and result register
    localparam int DONE_CYCLES = 3 * ARRAY_SIZE + MULT_LATENCY + 2;

    typedef logic signed [OPERAND_W-1:0] operand_t;
    typedef logic signed [PRODUCT_W-1:0] product_t;

    // one recoded digit
    // mag is 0..4 times y, neg flips the sign of the selected multiple
    typedef struct packed {
        logic [2:0] mag;
        logic       neg;
    } booth_digit_t;

    // digit 0 is the least significant group
    typedef struct packed {
        booth_digit_t [NUM_DIGITS-1:0] digit;
    } booth_word_t;

    // one operand per row or per column
    typedef operand_t [ARRAY_SIZE-1:0] operand_lanes_t;

    // accumulators, row-major, element [i][j] holds c[i][j]
    typedef product_t [ARRAY_SIZE-1:0][ARRAY_SIZE-1:0] result_grid_t;

endpackage

// File: booth_recoder.sv
`timescale 1ns/1ps

module booth_recoder (
    input  logic                      clk,
    input  logic                      rst,
    input  systolic_pkg::operand_t    a,
    output systolic_pkg::booth_word_t digits
);
    import systolic_pkg::*;

    // sign bit on top, zero appended below the lsb
    logic [OPERAND_W+1:0] scan;
    booth_word_t          digits_next;

    // overlapping 4-bit group to signed digit in the range -4..4
    function automatic booth_digit_t encode(input logic [3:0] grp);
        booth_digit_t dg;
        dg.neg = grp[3] & ~(&grp[2:0]);
        case (grp)
            4'b0000, 4'b1111: dg.mag = 3'd0;
            4'b0001, 4'b0010, 4'b1101, 4'b1110: dg.mag = 3'd1;
            4'b0011, 4'b0100, 4'b1011, 4'b1100: dg.mag = 3'd2;
            4'b0101, 4'b0110, 4'b1001, 4'b1010: dg.mag = 3'd3;
            default: dg.mag = 3'd4;
        endcase
        return dg;
    endfunction

    // signed value of one recoded digit
    function automatic int digit_value(input booth_digit_t dg);
        return dg.neg ? -int'(dg.mag) : int'(dg.mag);
    endfunction

    assign scan = {a[OPERAND_W-1], a, 1'b0};

    always_comb begin
        for (int k = 0; k < NUM_DIGITS; k++) begin
            digits_next.digit[k] = encode(scan[3*k +: 4]);
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            digits <= '0;
        end else begin
            digits <= digits_next;
        end
    end

    // the multiplier only knows multiples up to 4y
    // and the weighted digits must give back the operand they came from
    a_mag_range: assert property (@(posedge clk) disable iff (!rst)
        $past(rst) |->
            (digits.digit[0].mag <= 3'd4 && digits.digit[1].mag <= 3'd4 &&
             digits.digit[2].mag <= 3'd4 &&
             digit_value(digits.digit[0]) + 8 * digit_value(digits.digit[1]) +
             64 * digit_value(digits.digit[2]) == int'($past(a))));

endmodule

// File: booth_multiplier.sv
`timescale 1ns/1ps

module booth_multiplier (
    input  logic                      clk,
    input  logic                      rst,
    input  systolic_pkg::booth_word_t digits,
    input  systolic_pkg::operand_t    y,
    output systolic_pkg::product_t    product
);
    import systolic_pkg::*;

    // stage 1 registers
    booth_word_t                digits_q;
    operand_t                   y_q;
    logic signed [OPERAND_W+1:0] y3_q;
    logic signed [OPERAND_W+1:0] y3;

    // partial products and carry-save words
    product_t y_ext;
    product_t y3_ext;
    product_t pp [NUM_DIGITS];
    product_t cs_sum;
    product_t cs_maj;
    product_t sum_q;
    product_t carry_q;

    // final adder
    product_t             cpa_sum;
    logic [PRODUCT_W:0]   ripple;

    function automatic product_t select_multiple(
        input booth_digit_t dg,
        input product_t     y1,
        input product_t     y3m
    );
        product_t mult;
        case (dg.mag)
            3'd1:    mult = y1;
            3'd2:    mult = y1 <<< 1;
            3'd3:    mult = y3m;
            3'd4:    mult = y1 <<< 2;
            default: mult = '0;
        endcase
        return dg.neg ? -mult : mult;
    endfunction

    // 3y = 2y + y, ten bits hold the full signed range
    assign y3 = {y[OPERAND_W-1], y, 1'b0} + {{2{y[OPERAND_W-1]}}, y};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            digits_q <= '0;
            y_q      <= '0;
            y3_q     <= '0;
        end else begin
            digits_q <= digits;
            y_q      <= y;
            y3_q     <= y3;
        end
    end

    assign y_ext  = {{(PRODUCT_W-OPERAND_W){y_q[OPERAND_W-1]}}, y_q};
    assign y3_ext = {{(PRODUCT_W-OPERAND_W-2){y3_q[OPERAND_W+1]}}, y3_q};

    // digit k carries weight 8^k
    always_comb begin
        for (int k = 0; k < NUM_DIGITS; k++) begin
            pp[k] = select_multiple(digits_q.digit[k], y_ext, y3_ext) << (3 * k);
        end
    end

    // one row of full adders, three words into two
    assign cs_sum = pp[0] ^ pp[1] ^ pp[2];
    assign cs_maj = (pp[0] & pp[1]) | (pp[0] & pp[2]) | (pp[1] & pp[2]);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sum_q   <= '0;
            carry_q <= '0;
        end else begin
            sum_q   <= cs_sum;
            carry_q <= {cs_maj[PRODUCT_W-2:0], 1'b0};
        end
    end

    // ripple carry adder, the carry out of the top bit drops off (mod 2^16)
    always_comb begin
        ripple[0] = 1'b0;
        for (int k = 0; k < PRODUCT_W; k++) begin
            cpa_sum[k]    = sum_q[k] ^ carry_q[k] ^ ripple[k];
            ripple[k + 1] = (sum_q[k] & carry_q[k]) | (ripple[k] & (sum_q[k] ^ carry_q[k]));
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            product <= '0;
        end else begin
            product <= cpa_sum;
        end
    end

endmodule

// File: mac_cell.sv
`timescale 1ns/1ps

module mac_cell (
    input  logic                      clk,
    input  logic                      rst,
    input  systolic_pkg::booth_word_t digits_in,
    input  systolic_pkg::operand_t    y_in,
    output systolic_pkg::booth_word_t digits_out,
    output systolic_pkg::operand_t    y_out,
    output systolic_pkg::product_t    acc
);
    import systolic_pkg::*;

    product_t product;

    // the multiplier sees the operands in the same cycle they are forwarded
    booth_multiplier u_mult (
        .clk     (clk),
        .rst     (rst),
        .digits  (digits_in),
        .y       (y_in),
        .product (product)
    );

    // forward one hop right and one hop down
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            digits_out <= '0;
            y_out      <= '0;
        end else begin
            digits_out <= digits_in;
            y_out      <= y_in;
        end
    end

    // output-stationary sum, wraps at 16 bits
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            acc <= '0;
        end else begin
            acc <= acc + product;
        end
    end

endmodule

// File: array_ctrl.sv
`timescale 1ns/1ps

module array_ctrl (
    input  logic clk,
    input  logic rst,
    output logic capture,
    output logic done
);
    import systolic_pkg::*;

    logic [$clog2(DONE_CYCLES+1)-1:0] count;

    // counts cycles since reset release and holds at DONE_CYCLES
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count <= '0;
        end else if (count != DONE_CYCLES) begin
            count <= count + 1'b1;
        end
    end

    // capture leads done by one cycle so c is loaded when done rises
    assign capture = (count >= DONE_CYCLES - 1);
    assign done    = (count == DONE_CYCLES);

    a_done_sticky: assert property (@(posedge clk) disable iff (!rst) done |=> done);

endmodule

// File: systolic_array.sv
`timescale 1ns/1ps

module systolic_array (
    input  logic                         clk,
    input  logic                         rst,
    input  systolic_pkg::operand_lanes_t a_lanes,
    input  systolic_pkg::operand_lanes_t b_lanes,
    output systolic_pkg::result_grid_t   c,
    output logic                         done
);
    import systolic_pkg::*;

    // digits move right, b moves down
    // the extra column and row catch what the edge cells forward
    booth_word_t    digit_net [ARRAY_SIZE][ARRAY_SIZE+1];
    operand_t       b_net     [ARRAY_SIZE+1][ARRAY_SIZE];
    operand_lanes_t b_edge;
    result_grid_t   acc_grid;
    logic           capture;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            b_edge <= '0;
        end else begin
            b_edge <= b_lanes;
        end
    end

    for (genvar i = 0; i < ARRAY_SIZE; i++) begin : g_row
        booth_recoder u_recoder (
            .clk    (clk),
            .rst    (rst),
            .a      (a_lanes[i]),
            .digits (digit_net[i][0])
        );

        assign b_net[0][i] = b_edge[i];

        for (genvar j = 0; j < ARRAY_SIZE; j++) begin : g_col
            mac_cell u_cell (
                .clk        (clk),
                .rst        (rst),
                .digits_in  (digit_net[i][j]),
                .y_in       (b_net[i][j]),
                .digits_out (digit_net[i][j+1]),
                .y_out      (b_net[i+1][j]),
                .acc        (acc_grid[i][j])
            );
        end
    end

    array_ctrl u_ctrl (
        .clk     (clk),
        .rst     (rst),
        .capture (capture),
        .done    (done)
    );

    // result register follows the accumulators once capture is up
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            c <= '0;
        end else if (capture) begin
            c <= acc_grid;
        end
    end

    // c must have been loaded on the edge where done rose
    a_capture_before_done: assert property (@(posedge clk) disable iff (!rst)
        $rose(done) |-> $past(capture));

endmodule

// File: tb_systolic_array.sv
`timescale 1ns/1ps

module tb_systolic_array;
    import systolic_pkg::*;

    localparam int TIMEOUT_CYCLES = 100;

    logic           clk;
    logic           rst;
    operand_lanes_t a_lanes;
    operand_lanes_t b_lanes;
    result_grid_t   c;
    logic           done;

    // operands of the current run and their reference product
    operand_t mat_a    [ARRAY_SIZE][ARRAY_SIZE];
    operand_t mat_b    [ARRAY_SIZE][ARRAY_SIZE];
    product_t expected [ARRAY_SIZE][ARRAY_SIZE];

    logic [31:0] lcg_state;
    int          test_errors;
    int          tests_run;
    int          tests_failed;

    systolic_array u_dut (
        .clk     (clk),
        .rst     (rst),
        .a_lanes (a_lanes),
        .b_lanes (b_lanes),
        .c       (c),
        .done    (done)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // upper bits of the lcg have the longer period
    function automatic operand_t random_operand();
        lcg_state = lcg_next(lcg_state);
        return operand_t'(lcg_state[23:16]);
    endfunction

    task automatic clear_matrices();
        for (int i = 0; i < ARRAY_SIZE; i++) begin
            for (int j = 0; j < ARRAY_SIZE; j++) begin
                mat_a[i][j] = '0;
                mat_b[i][j] = '0;
            end
        end
    endtask

    // plain triple loop, wrapped to 16 bits
    task automatic compute_reference();
        int sum;
        for (int i = 0; i < ARRAY_SIZE; i++) begin
            for (int j = 0; j < ARRAY_SIZE; j++) begin
                sum = 0;
                for (int k = 0; k < ARRAY_SIZE; k++) begin
                    sum += int'(mat_a[i][k]) * int'(mat_b[k][j]);
                end
                expected[i][j] = sum[PRODUCT_W-1:0];
            end
        end
    endtask

    task automatic reset_dut();
        @(posedge clk);
        rst     <= 1'b0;
        a_lanes <= '0;
        b_lanes <= '0;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
    endtask

    // row i delayed by i cycles, column j delayed by j cycles
    task automatic stream_matrices();
        operand_lanes_t a_next;
        operand_lanes_t b_next;
        for (int k = 0; k <= 3 * ARRAY_SIZE; k++) begin
            for (int n = 0; n < ARRAY_SIZE; n++) begin
                if (k - n >= 0 && k - n < ARRAY_SIZE) begin
                    a_next[n] = mat_a[n][k-n];
                    b_next[n] = mat_b[k-n][n];
                end else begin
                    a_next[n] = '0;
                    b_next[n] = '0;
                end
            end
            @(posedge clk);
            a_lanes <= a_next;
            b_lanes <= b_next;
        end
        @(posedge clk);
        a_lanes <= '0;
        b_lanes <= '0;
    endtask

    task automatic wait_for_done(input string name);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!done && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            $display("%s: done did not rise within %0d cycles", name, TIMEOUT_CYCLES);
            test_errors++;
        end
    endtask

    task automatic check_result(input string name);
        product_t got;
        for (int i = 0; i < ARRAY_SIZE; i++) begin
            for (int j = 0; j < ARRAY_SIZE; j++) begin
                got = c[i][j];
                if (got !== expected[i][j]) begin
                    $display("Fail %s c[%0d][%0d] expected %0d actual %0d",
                             name, i, j, expected[i][j], got);
                    test_errors++;
                end
            end
        end
    endtask

    task automatic run_product(input string name);
        compute_reference();
        reset_dut();
        stream_matrices();
        wait_for_done(name);
        if (done) begin
            check_result(name);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
            $display("%s: %0d errors", name, test_errors);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    task automatic after_reset();
        test_errors = 0;
        clear_matrices();
        compute_reference();
        reset_dut();
        @(negedge clk);
        if (done !== 1'b0) begin
            $display("Fail after_reset done expected 0 actual %b", done);
            test_errors++;
        end
        if (c !== '0) begin
            $display("Fail after_reset c expected 0 actual %h", c);
            test_errors++;
        end
        stream_matrices();
        wait_for_done("after_reset");
        if (done) begin
            check_result("after_reset");
        end
        finish_test("after_reset");
    endtask

    task automatic identity_product();
        test_errors = 0;
        clear_matrices();
        for (int i = 0; i < ARRAY_SIZE; i++) begin
            mat_a[i][i] = 8'sd1;
            for (int j = 0; j < ARRAY_SIZE; j++) begin
                mat_b[i][j] = operand_t'(i * ARRAY_SIZE + j + 1);
            end
        end
        run_product("identity_product");
        finish_test("identity_product");
    endtask

    // one nonzero a against one nonzero b, moved around the grid
    task automatic digit_magnitudes();
        operand_t a_vals [6] = '{8'sd3, 8'sd4, -8'sd3, -8'sd4, 8'sd7, 8'sd127};
        operand_t b_vals [4] = '{8'sd1, -8'sd1, 8'sd5, -8'sd5};
        int       idx;
        test_errors = 0;
        idx = 0;
        foreach (a_vals[p]) begin
            foreach (b_vals[q]) begin
                clear_matrices();
                mat_a[idx % ARRAY_SIZE][(idx + 1) % ARRAY_SIZE] = a_vals[p];
                mat_b[(idx + 1) % ARRAY_SIZE][(idx + 2) % ARRAY_SIZE] = b_vals[q];
                run_product("digit_magnitudes");
                idx++;
            end
        end
        finish_test("digit_magnitudes");
    endtask

    task automatic extreme_values();
        test_errors = 0;
        for (int i = 0; i < ARRAY_SIZE; i++) begin
            for (int j = 0; j < ARRAY_SIZE; j++) begin
                mat_a[i][j] = -8'sd128;
                mat_b[i][j] = -8'sd128;
            end
        end
        run_product("extreme_values");
        for (int i = 0; i < ARRAY_SIZE; i++) begin
            for (int j = 0; j < ARRAY_SIZE; j++) begin
                mat_b[i][j] = 8'sd127;
            end
        end
        run_product("extreme_values");
        finish_test("extreme_values");
    endtask

    task automatic fill_random();
        for (int i = 0; i < ARRAY_SIZE; i++) begin
            for (int j = 0; j < ARRAY_SIZE; j++) begin
                mat_a[i][j] = random_operand();
                mat_b[i][j] = random_operand();
            end
        end
    endtask

    task automatic random_matrices();
        test_errors = 0;
        for (int n = 0; n < 10; n++) begin
            fill_random();
            run_product("random_matrices");
        end
        finish_test("random_matrices");
    endtask

    // done and c must hold while the inputs stay at zero
    task automatic done_hold();
        test_errors = 0;
        fill_random();
        run_product("done_hold");
        if (done) begin
            for (int n = 0; n < 10; n++) begin
                @(negedge clk);
                if (done !== 1'b1) begin
                    $display("Fail done_hold done expected 1 actual %b", done);
                    test_errors++;
                end
                check_result("done_hold");
            end
        end
        finish_test("done_hold");
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b0;
        a_lanes      = '0;
        b_lanes      = '0;
        lcg_state    = 32'hdb7c;
        tests_run    = 0;
        tests_failed = 0;

        after_reset();
        identity_product();
        digit_magnitudes();
        extreme_values();
        random_matrices();
        done_hold();

        $display("tests run %0d, failed %0d", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: sim.f
systolic_pkg.sv
booth_recoder.sv
booth_multiplier.sv
mac_cell.sv
array_ctrl.sv
systolic_array.sv
tb_systolic_array.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_systolic_array -f sim.f -o sim_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi

exit 0
